/* predecoder.f */
src/predecIsaPkg.sv
src/predecGeomPkg.sv
src/parcelBus.sv
src/parcelClassifier.sv
src/parcelFront.sv
src/slotSelector.sv
src/predecoder.sv
testbench/tbPredecoder.sv

/* Bender.yml */
package:
  name: predecoder

sources:
  - src/predecIsaPkg.sv
  - src/predecGeomPkg.sv
  - src/parcelBus.sv
  - src/parcelClassifier.sv
  - src/parcelFront.sv
  - src/slotSelector.sv
  - src/predecoder.sv
  - target: test
    files:
      - testbench/tbPredecoder.sv

/* testbench/tbPredecoder.sv */
`timescale 1ns/1ps

module tbPredecoder;
  import predecGeomPkg::*;
  import predecIsaPkg::*;

  localparam int clkPeriod       = 4;
  localparam int resetCycles     = 16;
  localparam int randomVectors   = 400;
  localparam int directedVectors = 6;

  typedef struct packed {
    slotRec [instrSlots-1:0] slots;
    logic [instrSlots-1:0]   instrEn;
    slotRec [jumpSlots-1:0]  jumps;
    logic [jumpSlots-1:0]    jumpEn;
    logic                    isAvx;
    logic                    error;
    logic                    jerror;
  } expectT;

  logic                    clk = 1'b0;
  logic                    rst;
  logic [255:0]            bundle;
  logic [16:0]             btail;
  logic [14:0]             flagBits;
  logic [offBits-1:0]      startOff;
  slotRec [instrSlots-1:0] slots;
  logic [instrSlots-1:0]   instrEn;
  slotRec [jumpSlots-1:0]  jumps;
  logic [jumpSlots-1:0]    jumpEn;
  logic                    isAvx;
  logic                    error;
  logic                    jerror;

  logic [15:0] lfsrState = 16'd27;
  expectT      expQ [$];       // bundles latched but not yet checked
  expectT      pending;
  logic        havePending = 1'b0;
  int          driven = 0;
  int          compared = 0;

  always #(clkPeriod / 2) clk = ~clk;

  predecoder dut (
    .clk      (clk),
    .rst      (rst),
    .bundle   (bundle),
    .btail    (btail),
    .flagBits (flagBits),
    .startOff (startOff),
    .slots    (slots),
    .instrEn  (instrEn),
    .jumps    (jumps),
    .jumpEn   (jumpEn),
    .isAvx    (isAvx),
    .error    (error),
    .jerror   (jerror)
  );

  // ==================================================
  // stimulus source and reference model
  // ==================================================
  function automatic logic [15:0] lfsrNext(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
  endfunction

  function automatic logic [255:0] takeBits(int n);
    logic [255:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      r[i] = lfsrState[0];
    end
    return r;
  endfunction

  function automatic classVec classify(logic [31:0] ins, logic longForm, logic flag);
    classVec    c;
    int         op;
    logic [2:0] sub;
    logic       sysJ;
    logic       mem;
    c    = '0;
    op   = ins[7:0];
    sub  = ins[15:13];
    sysJ = op == 255 && !ins[15] && !ins[13];
    mem  = (op >= 60 && op <= 159) || op == 176 || op == 177;
    c[clsFlag] = flag;
    if (longForm) begin
      c[clsJump]   = (op >= 160 && op <= 175) || (op >= 178 && op <= 182) || sysJ;
      c[clsIndir]  = (op == 182 && (sub == 0 || sub == 3)) || sysJ;
      c[clsAlu]    = (op < 40 && !ins[2]) || (op >= 46 && op <= 49) || op == 52 ||
                     op == 53 || (op >= 160 && op <= 175) || op == 178 || op == 179 ||
                     (op >= 183 && op <= 197) || op == 210 || op == 211 ||
                     (op == 198 && ins[31:29] == 3'd0);
      c[clsShift]  = op >= 40 && op <= 45;
      c[clsMul]    = (op < 40 && ins[2]) || sysJ;
      c[clsLoad]   = (mem && !ins[0]) || op == 54 || op == 55 || op == 176 || op == 177;
      c[clsStore]  = (mem && ins[0]) || (op == 182 && (sub == 1 || sub == 2));
      c[clsStore2] = op >= 112 && op <= 159 && ins[0];
      c[clsSys]    = op == 255;
    end
    return c;
  endfunction

  function automatic expectT predictBundle(logic [255:0] b, logic [16:0] t,
                                           logic [14:0] fl, logic [3:0] off);
    expectT       e;
    logic [319:0] d;
    logic [15:0]  ends;
    logic [18:0]  endsExt;
    slotRec       r;
    logic         starts;
    int           n;
    int           nj;
    e       = '0;
    d       = {64'd0, t[15:0], b[239:0]};
    ends    = {t[16], b[254:240]};
    endsExt = {3'b000, ends}; // no end bits past parcel 15
    n       = 0;
    nj      = 0;
    for (int k = 0; k < parcelCount; k++) begin
      starts = 1'b1;
      if (k > 0)
        starts = ends[k-1];
      if (k >= off && starts) begin
        r.instr = d[k*16 +: 80];
        r.magic = endsExt[k +: 4];
        r.off   = 4'(k);
        r.cls   = classify(d[k*16 +: 32], !ends[k], (k < 15) ? fl[k] : t[16]);
        if (n < instrSlots) begin
          e.slots[n]   = r;
          e.instrEn[n] = 1'b1;
        end
        n++;
        if (r.cls[clsJump]) begin
          if (nj < jumpSlots) begin
            e.jumps[nj]  = r;
            e.jumpEn[nj] = 1'b1;
          end
          nj++;
        end
      end
    end
    e.error  = n > instrSlots || off == 4'd15;
    e.jerror = nj > jumpSlots;
    e.isAvx  = b[255];
    return e;
  endfunction

  // ==================================================
  // checks
  // ==================================================
  task automatic abortRun();
    $display("Errors found");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic checkSlot(string name, int idx, slotRec got, slotRec exp);
    if (got !== exp) begin
      $display("MISMATCH %s[%0d] got %h expected %h", name, idx, got, exp);
      abortRun();
    end
  endtask

  task automatic checkEn(string name, logic [instrSlots-1:0] got, logic [instrSlots-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      abortRun();
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      abortRun();
    end
  endtask

  task automatic compareOutputs(expectT e);
    for (int s = 0; s < instrSlots; s++) begin
      checkSlot("slots", s, slots[s], e.slots[s]);
    end
    for (int s = 0; s < jumpSlots; s++) begin
      checkSlot("jumps", s, jumps[s], e.jumps[s]);
    end
    checkEn("instrEn", instrEn, e.instrEn);
    checkEn("jumpEn", instrSlots'(jumpEn), instrSlots'(e.jumpEn));
    checkFlag("isAvx", isAvx, e.isAvx);
    checkFlag("error", error, e.error);
    checkFlag("jerror", jerror, e.jerror);
  endtask

  // result of the bundle latched at the previous edge is visible now
  always @(posedge clk) begin
    if (havePending) begin
      compareOutputs(pending);
      compared++;
    end
    havePending = expQ.size() > 0;
    if (havePending) begin
      pending = expQ.pop_front();
    end
  end

  // ==================================================
  // drivers
  // ==================================================
  task automatic driveBundle(logic [255:0] b, logic [16:0] t, logic [14:0] f, logic [3:0] o);
    bundle   = b;
    btail    = t;
    flagBits = f;
    startOff = o;
    expQ.push_back(predictBundle(b, t, f, o));
    driven++;
    @(negedge clk);
  endtask

  // two-parcel words at the even parcels, returned as {btail, bundle}
  function automatic logic [272:0] packWords(logic [7:0][31:0] words, logic avx);
    logic [255:0] b;
    logic [16:0]  t;
    b = words;
    t = {1'b1, b[255:240]}; // upper half of parcel 14 lives in btail
    b[255:240] = '0;
    for (int k = 1; k < 15; k += 2) begin
      b[240 + k] = 1'b1;
    end
    b[255] = avx;
    return {t, b};
  endfunction

  // eight two-parcel instructions at the even parcels
  task automatic driveWords(logic [7:0][31:0] words, logic avx, logic [3:0] o);
    logic [272:0] p;
    p = packWords(words, avx);
    driveBundle(p[255:0], p[272:256], 15'h2aaa, o);
  endtask

  initial begin
    #((resetCycles + randomVectors + directedVectors + 40) * clkPeriod);
    $display("timeout, results did not drain within the expected run time");
    abortRun();
  end

  initial begin
    logic [255:0] r;
    logic [255:0] t;
    logic [255:0] f;
    logic [255:0] o;
    logic [272:0] p;
    rst      = 1'b1;
    p        = packWords({8{32'h000000B5}}, 1'b1);
    bundle   = p[255:0];    // eight jumps held through reset
    btail    = p[272:256];
    flagBits = 15'h2aaa;
    startOff = '0;
    repeat (resetCycles / 2) @(posedge clk);
    @(negedge clk);
    compareOutputs('0);
    startOff = 4'd15;       // bad start while still in reset
    repeat (resetCycles - resetCycles / 2) @(posedge clk);
    @(negedge clk);
    compareOutputs('0);
    rst = 1'b0;

    driveWords({32'h000000B4, 32'h000000B2, 32'h000000A3, 32'h00000035,
                32'h0000002F, 32'h0000002A, 32'h00000004, 32'h00000001}, 1'b1, 4'd0);
    driveWords({32'h000000D2, 32'h200000C6, 32'h000000C6, 32'h000000B7,
                32'h000060B6, 32'h000040B6, 32'h000020B6, 32'h000000B6}, 1'b0, 4'd0);
    driveWords({32'h0000A0FF, 32'h000000FF, 32'h0000003C, 32'h000000B0,
                32'h00000036, 32'h00000071, 32'h00000041, 32'h00000040}, 1'b0, 4'd0);
    driveWords({8{32'h000000B5}}, 1'b1, 4'd0); // eight jumps
    r = takeBits(256);
    r[254:240] = '1;  // every parcel a one-parcel instruction
    t = takeBits(16);
    driveBundle(r, {1'b1, t[15:0]}, 15'h4c3a, 4'd0);
    r = takeBits(256);
    t = takeBits(17);
    driveBundle(r, t[16:0], 15'h1234, 4'd15);

    for (int i = 0; i < randomVectors; i++) begin
      r = takeBits(256);
      t = takeBits(17);
      f = takeBits(15);
      o = takeBits(4);
      driveBundle(r, t[16:0], f[14:0], o[3:0]);
    end

    while (expQ.size() != 0 || havePending) @(negedge clk);
    if (compared == driven) begin
      $display("No errors");
      $finish;
    end else begin
      $display("only %0d of %0d bundles were checked", compared, driven);
      abortRun();
    end
  end

endmodule

/* src/predecoder.sv */
`timescale 1ns/1ps

module predecoder (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic [255:0]                                         bundle,
  input  logic [16:0]                                          btail,
  input  logic [14:0]                                          flagBits,
  input  logic [predecGeomPkg::offBits-1:0]                    startOff,
  output predecGeomPkg::slotRec [predecGeomPkg::instrSlots-1:0] slots,
  output logic [predecGeomPkg::instrSlots-1:0]                 instrEn,
  output predecGeomPkg::slotRec [predecGeomPkg::jumpSlots-1:0]  jumps,
  output logic [predecGeomPkg::jumpSlots-1:0]                  jumpEn,
  output logic                                                 isAvx,
  output logic                                                 error,
  output logic                                                 jerror
);
  import predecGeomPkg::*;

  parcelMask startPick;
  parcelMask jumpPick;
  logic      instrOverflow;

  parcelBus bus ();

  // ==================================================
  // decode front and the two compaction stages
  // ==================================================
  parcelFront front (
    .clk       (clk),
    .rst       (rst),
    .bundle    (bundle),
    .btail     (btail),
    .flagBits  (flagBits),
    .startOff  (startOff),
    .overflow  (instrOverflow),
    .bus       (bus.front),
    .startPick (startPick),
    .jumpPick  (jumpPick),
    .isAvx     (isAvx),
    .badStart  (error)       // bad start or too many instructions
  );

  slotSelector #(.slotCount(instrSlots)) instrSel (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus.select),
    .pick     (startPick),
    .slots    (slots),
    .en       (instrEn),
    .overflow (instrOverflow)
  );

  slotSelector #(.slotCount(jumpSlots)) jumpSel (
    .clk      (clk),
    .rst      (rst),
    .bus      (bus.select),
    .pick     (jumpPick),
    .slots    (jumps),
    .en       (jumpEn),
    .overflow (jerror)
  );

endmodule

/* src/slotSelector.sv */
`timescale 1ns/1ps

module slotSelector #(
  parameter int slotCount = predecGeomPkg::instrSlots
) (
  input  logic                                   clk,
  input  logic                                   rst,
  parcelBus.select                               bus,
  input  predecGeomPkg::parcelMask               pick,
  output predecGeomPkg::slotRec [slotCount-1:0]  slots,
  output logic [slotCount-1:0]                   en,
  output logic                                   overflow
);
  import predecGeomPkg::*;

  localparam int rankBits = $clog2(parcelCount + 1);

  logic [rankBits-1:0]  prefix [parcelCount]; // picks below parcel k
  logic [rankBits-1:0]  total;
  slotRec [slotCount-1:0] slotD;
  logic [slotCount-1:0] enD;

  // ==================================================
  // rank of every picked parcel
  // ==================================================
  always_comb begin
    logic [rankBits-1:0] acc;
    acc = '0;
    for (int k = 0; k < parcelCount; k++) begin
      prefix[k] = acc;
      acc = acc + rankBits'(pick[k]);
    end
    total = acc;
  end

  // slot s takes the picked parcel of rank s
  always_comb begin
    slotD = '0;
    for (int s = 0; s < slotCount; s++) begin
      enD[s] = total > rankBits'(s);
      for (int k = 0; k < parcelCount; k++) begin
        if (pick[k] && prefix[k] == rankBits'(s)) begin
          slotD[s].instr = bus.window[k];
          slotD[s].magic = bus.magic[k];
          slotD[s].off   = offBits'(k);
          slotD[s].cls   = bus.cls[k];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      slots    <= '0;
      en       <= '0;
      overflow <= 1'b0;
    end else begin
      slots    <= slotD;
      en       <= enD;
      overflow <= total > rankBits'(slotCount); // extra starts are dropped
    end
  end

endmodule

/* src/parcelFront.sv */
`timescale 1ns/1ps

module parcelFront (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [255:0]                      bundle,
  input  logic [16:0]                       btail,
  input  logic [14:0]                       flagBits,
  input  logic [predecGeomPkg::offBits-1:0] startOff,
  input  logic                              overflow, // registered slot overflow
  parcelBus.front                           bus,
  output predecGeomPkg::parcelMask          startPick,
  output predecGeomPkg::parcelMask          jumpPick,
  output logic                              isAvx,
  output logic                              badStart
);
  import predecGeomPkg::*;
  import predecIsaPkg::*;

  localparam int dataBits = parcelCount * parcelBits + instrBits - parcelBits;

  logic [dataBits-1:0]              data;
  logic [parcelCount+magicBits-2:0] endExt;
  parcelMask                        endBits;
  parcelMask                        startBits;
  parcelMask                        offMask;
  parcelMask                        jumpBits;
  parcelMask                        flags;
  classVec                          clsAll [parcelCount];
  logic                             badStartQ;

  // ==================================================
  // bundle fields
  // ==================================================
  assign endBits   = {btail[16], bundle[254:240]};
  assign endExt    = {{(magicBits - 1){1'b0}}, endBits};
  assign data      = {{(dataBits - 256){1'b0}}, btail[15:0], bundle[239:0]};
  assign flags     = {btail[16], flagBits};
  assign startBits = {endBits[parcelCount-2:0], 1'b1}; // parcel 0 always starts

  for (genvar k = 0; k < parcelCount; k++) begin : gClass
    parcelClassifier classifier (
      .instr    (data[k*parcelBits +: 32]),
      .longForm (~endBits[k]),
      .flag     (flags[k]),
      .cls      (clsAll[k])
    );
  end

  always_comb begin
    for (int k = 0; k < parcelCount; k++) begin
      bus.window[k] = data[k*parcelBits +: instrBits];
      bus.magic[k]  = endExt[k +: magicBits];
      bus.cls[k]    = clsAll[k];
      offMask[k]    = offBits'(k) >= startOff;
      jumpBits[k]   = clsAll[k][clsJump];
    end
  end

  assign startPick = startBits & offMask;
  assign jumpPick  = startPick & jumpBits;

  // kept in step with the slot registers
  always_ff @(posedge clk) begin
    if (rst) begin
      isAvx     <= 1'b0;
      badStartQ <= 1'b0;
    end else begin
      isAvx     <= bundle[255];
      badStartQ <= startOff == offBits'(parcelCount - 1);
    end
  end

  assign badStart = badStartQ | overflow; // drives the top-level error
endmodule

/* src/parcelClassifier.sv */
`timescale 1ns/1ps

module parcelClassifier (
  input  logic [31:0]           instr,
  input  logic                  longForm, // own end bit clear
  input  logic                  flag,
  output predecIsaPkg::classVec cls
);
  import predecIsaPkg::*;

  logic [7:0] op;
  logic [2:0] indSub;
  logic       condBr;
  logic       basicArith;
  logic       memRange;
  logic       isSys;
  logic       sysJump;
  logic       indirRet;
  logic       callSub;
  logic       aluTerm;

  assign op     = instr[7:0];
  assign indSub = instr[15:13];

  // ==================================================
  // opcode groups
  // ==================================================
  assign condBr     = op[7:4] == 4'hA;        // 160..175
  assign basicArith = op < 8'd40;             // alu when bit 2 clear, mul when set
  assign memRange   = op inside {[60:159], [176:177]};
  assign isSys      = op == opSys;
  assign sysJump    = isSys && !instr[15] && !instr[13];

  assign indirRet = op == opIndir && (indSub == 3'd0 || indSub == 3'd3);
  assign callSub  = op == opIndir && (indSub == 3'd1 || indSub == 3'd2); // call stores the link

  assign aluTerm = (basicArith && !op[2]) ||
                   op inside {[46:49], [52:53]} ||                // compare / test
                   condBr ||
                   op inside {opSelfTestJ0, opSelfTestJ1} ||
                   op inside {opMov, [184:191], [192:193]} ||     // mov and extend
                   op inside {opCSet, opAddNoFl0, opAddNoFl1, opLeaIp} ||
                   op inside {opShlAdd0, opShlAdd1} ||
                   (op == opCmov && instr[31:29] == 3'd0);

  // ==================================================
  // class vector
  // ==================================================
  always_comb begin
    cls = '0;
    cls[clsJump] = longForm && (condBr || sysJump ||
                   op inside {opSelfTestJ0, opSelfTestJ1, opLongJ, opJump, opIndir});
    cls[clsIndir]  = longForm && (indirRet || sysJump);
    cls[clsAlu]    = longForm && aluTerm;
    cls[clsShift]  = longForm && op inside {[40:45]};
    cls[clsMul]    = longForm && ((basicArith && op[2]) || sysJump);
    cls[clsLoad]   = longForm && ((memRange && !op[0]) || op inside {54, 55, 176, 177});
    cls[clsStore]  = longForm && ((memRange && op[0]) || callSub);
    cls[clsStore2] = longForm && op inside {[112:159]} && op[0]; // indexed store
    cls[clsSys]    = longForm && isSys;
    cls[clsFlag]   = flag;   // short parcels keep only this
  end

endmodule

/* src/parcelBus.sv */
`timescale 1ns/1ps

// per-parcel decode results, broadcast to both slot selectors
interface parcelBus;
  import predecGeomPkg::*;
  import predecIsaPkg::*;

  logic [instrBits-1:0] window [parcelCount]; // instruction window
  logic [magicBits-1:0] magic [parcelCount];
  classVec              cls [parcelCount];

  modport front (
    output window,
    output magic,
    output cls
  );

  modport select (
    input window,
    input magic,
    input cls
  );

endinterface

/* src/predecGeomPkg.sv */
package predecGeomPkg;

  localparam int parcelBits  = 16;
  localparam int parcelCount = 16;
  localparam int instrSlots  = 12;
  localparam int jumpSlots   = 4;

  // five parcels starting at the slot's parcel
  localparam int instrBits = 80;
  localparam int magicBits = 4;
  localparam int offBits   = 4;

  typedef logic [parcelCount-1:0] parcelMask; // one bit per parcel

  // one decoded instruction slot
  typedef struct packed {
    logic [instrBits-1:0]  instr;
    logic [magicBits-1:0]  magic; // end bits from the start parcel on
    logic [offBits-1:0]    off;   // start parcel number
    predecIsaPkg::classVec cls;
  } slotRec;

endpackage

/* src/predecIsaPkg.sv */
package predecIsaPkg;

  // ==================================================
  // class vector bit positions
  // ==================================================
  typedef enum logic [3:0] {
    clsIndir  = 4'd0,
    clsJump   = 4'd1,
    clsAlu    = 4'd2,
    clsShift  = 4'd3,
    clsMul    = 4'd4,
    clsLoad   = 4'd5,
    clsStore  = 4'd6,
    clsStore2 = 4'd7,
    clsSys    = 4'd8,
    clsFlag   = 4'd9
  } iclassE;

  localparam int classBits = 10;

  typedef logic [classBits-1:0] classVec; // indexed by iclassE

  // ==================================================
  // main opcodes with a single fixed value
  // ==================================================
  typedef enum logic [7:0] {
    opSelfTestJ0 = 8'd178,
    opSelfTestJ1 = 8'd179,
    opLongJ      = 8'd180, // long conditional jump
    opJump       = 8'd181, // unconditional
    opIndir      = 8'd182, // indirect, call, return by sub-code
    opMov        = 8'd183,
    opCSet       = 8'd194,
    opAddNoFl0   = 8'd195,
    opAddNoFl1   = 8'd196,
    opLeaIp      = 8'd197,
    opCmov       = 8'd198,
    opShlAdd0    = 8'd210,
    opShlAdd1    = 8'd211,
    opSys        = 8'hFF
  } mainOpE;

endpackage
